// ==== logic/rsa_array_pkg.sv ====
// array geometry and datapath word types, imported by every module that moves matrix data
`default_nettype none

package rsa_array_pkg;

    localparam int ROWS   = 4;   // array rows
    localparam int COLS   = 4;   // array columns
    localparam int DEPTH  = 4;   // inner dimension, operand pairs per cell
    localparam int DATA_W = 16;  // word width

    typedef logic signed [DATA_W-1:0] data_t;  // all arithmetic wraps modulo 2^16

    // west edge slice, or one drained column of results
    typedef struct packed {
        data_t [ROWS-1:0] w;  // one word per array row
    } row_vec_t;

    typedef struct packed {
        data_t [COLS-1:0] w;  // one word per array column, south edge slice
    } col_vec_t;

    // indexed [row][k], the same shape serves A, B and M
    typedef data_t [ROWS-1:0][DEPTH-1:0] mat_t;

endpackage

`default_nettype wire

// ==== logic/rsa_ctrl_pkg.sv ====
// job descriptor, adder opcodes and sequencer states, imported by the control side of the array
`default_nettype none

package rsa_ctrl_pkg;

    import rsa_array_pkg::*;

    localparam int FEED_LEN  = DEPTH + ROWS + COLS - 2;  // edge feed cycles per job
    localparam int LATCH_CYC = DEPTH + ROWS + COLS - 1;  // feed clock value once all cells latched
    localparam int CNT_W     = $clog2(LATCH_CYC + 1);
    localparam int DRAIN_W   = $clog2(COLS);

    typedef enum logic [1:0] {
        MODE_PASS = 2'd0,  // out = P
        MODE_ADD  = 2'd1,  // out = M + P
        MODE_SUB  = 2'd2   // out = M - P
    } add_mode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FEED,   // edges driven, strobes rippling through the grid
        SEQ_DRAIN   // results shifted out of column 0
    } seq_state_e;

    typedef struct packed {
        mat_t      a;
        mat_t      b;
        mat_t      m;
        add_mode_e mode;
    } job_t;

endpackage

`default_nettype wire

// ==== logic/pe_mac.sv ====
// one systolic cell, multiplies its operand pair into an accumulator and forwards operands on
`timescale 1ns/1ps
`default_nettype none

module pe_mac
    import rsa_array_pkg::*;
(
    input  wire        clk,
    input  wire        i_reset,
    input  wire data_t i_west,      // A operand from the west neighbor or edge
    input  wire data_t i_south,     // B operand from the south neighbor or edge
    input  wire        i_cal_en,    // clear, arrives with the first pair
    input  wire        i_cal_done,  // done, arrives one cycle after the last pair
    input  wire        i_shift,
    input  wire data_t i_din,       // result of the east neighbor
    output data_t      o_east,
    output data_t      o_north,
    output logic       o_cal_en,
    output logic       o_cal_done,
    output data_t      o_dout
);

    data_t prod;
    data_t acc_q;

    assign prod = i_west * i_south;  // low half kept

    // operands hop one cell per cycle
    always_ff @(posedge clk) begin
        o_east  <= i_west;
        o_north <= i_south;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cal_en   <= 1'b0;
            o_cal_done <= 1'b0;
        end else begin
            o_cal_en   <= i_cal_en;    // ripples on to the next cell
            o_cal_done <= i_cal_done;
        end
    end

    always_ff @(posedge clk) begin
        if (i_cal_en) begin
            acc_q <= prod;  // first pair of a job replaces the old sum
        end else begin
            acc_q <= acc_q + prod;
        end
    end

    // result stage, loaded on done and moved west during the drain
    always_ff @(posedge clk) begin
        if (i_cal_done) begin
            o_dout <= acc_q;
        end else if (i_shift) begin
            o_dout <= i_din;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pe_array.sv ====
// grid of multiply-accumulate cells with edge wiring, strobe ripple and the column 0 drain
`timescale 1ns/1ps
`default_nettype none

module pe_array
    import rsa_array_pkg::*;
(
    input  wire           clk,
    input  wire           i_reset,
    input  wire row_vec_t i_west,
    input  wire col_vec_t i_south,
    input  wire           i_cal_en,    // enters cell (0,0)
    input  wire           i_cal_done,  // enters cell (0,0)
    input  wire           i_shift,
    output row_vec_t      o_drain      // result stages of column 0
);

    data_t east_w  [ROWS][COLS+1];  // [i][0] is the west edge
    data_t north_w [ROWS+1][COLS];  // [0][j] is the south edge
    data_t dout_w  [ROWS][COLS+1];  // [i][COLS] shifts zeros into the east column
    logic  en_w    [ROWS][COLS];
    logic  done_w  [ROWS][COLS];

    for (genvar i = 0; i < ROWS; i++) begin : g_edge_row
        assign east_w[i][0]    = i_west.w[i];
        assign dout_w[i][COLS] = '0;
        assign o_drain.w[i]    = dout_w[i][0];
    end

    for (genvar j = 0; j < COLS; j++) begin : g_edge_col
        assign north_w[0][j] = i_south.w[j];
    end

    for (genvar i = 0; i < ROWS; i++) begin : g_row
        for (genvar j = 0; j < COLS; j++) begin : g_col
            logic en_in;
            logic done_in;

            // strobes go east along row 0, then north up every column
            if (i == 0 && j == 0) begin : g_src
                assign en_in   = i_cal_en;
                assign done_in = i_cal_done;
            end else if (i == 0) begin : g_east
                assign en_in   = en_w[0][j-1];
                assign done_in = done_w[0][j-1];
            end else begin : g_north
                assign en_in   = en_w[i-1][j];
                assign done_in = done_w[i-1][j];
            end

            pe_mac u_pe (
                .clk        (clk),
                .i_reset    (i_reset),
                .i_west     (east_w[i][j]),
                .i_south    (north_w[i][j]),
                .i_cal_en   (en_in),
                .i_cal_done (done_in),
                .i_shift    (i_shift),
                .i_din      (dout_w[i][j+1]),
                .o_east     (east_w[i][j+1]),
                .o_north    (north_w[i+1][j]),
                .o_cal_en   (en_w[i][j]),
                .o_cal_done (done_w[i][j]),
                .o_dout     (dout_w[i][j])
            );
        end
    end

endmodule

`default_nettype wire

// ==== logic/operand_feeder.sv ====
// holds A and B of a job and drives the skewed west and south edge lanes of the array
`timescale 1ns/1ps
`default_nettype none

module operand_feeder
    import rsa_array_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  wire       clk,
    input  wire       i_reset,
    input  wire       i_load,   // capture A and B
    input  wire mat_t i_a,
    input  wire mat_t i_b,
    input  wire       i_feed,   // one feed step per cycle while high
    output row_vec_t  o_west,
    output col_vec_t  o_south
);

    mat_t             a_q;     // A[row][k]
    mat_t             b_q;     // B[k][col]
    logic [CNT_W-1:0] step_q;  // feed cycle f

    // lane gets element k = step - lane while its skew window is open, else zero
    function automatic data_t skew_pick(input mat_t m, input int lane, input int step,
                                        input logic by_col);
        int k;
        k = step - lane;
        if (k < 0 || k >= DEPTH) begin
            return '0;
        end
        return by_col ? m[k][lane] : m[lane][k];
    endfunction

    always_ff @(posedge clk) begin
        if (i_load) begin
            a_q <= i_a;
            b_q <= i_b;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            step_q <= '0;
        end else if (i_load) begin
            step_q <= '0;  // every job starts at f=0
        end else if (i_feed) begin
            step_q <= step_q + 1'b1;
        end
    end

    // registered edge lanes, zero outside the feed window
    always_ff @(posedge clk) begin
        for (int i = 0; i < ROWS; i++) begin
            o_west.w[i] <= i_feed ? skew_pick(a_q, i, int'(step_q), 1'b0) : '0;
        end
        for (int j = 0; j < COLS; j++) begin
            o_south.w[j] <= i_feed ? skew_pick(b_q, j, int'(step_q), 1'b1) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/result_adder.sv ====
// per-row output adder, passes each drained column or combines it with the matching M column
`timescale 1ns/1ps
`default_nettype none

module result_adder
    import rsa_array_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  wire            clk,
    input  wire            i_reset,
    input  wire            i_load,   // capture M and mode
    input  wire mat_t      i_m,
    input  wire add_mode_e i_mode,
    input  wire            i_beat,   // drained column present
    input  wire            i_last,   // final column of the job
    input  wire row_vec_t  i_drain,
    output logic           o_valid,
    output row_vec_t       o_col,
    output logic           o_done
);

    mat_t      m_q;     // slot 0 of every row holds the column under work
    add_mode_e mode_q;

    function automatic data_t apply_mode(input add_mode_e mode, input data_t m, input data_t p);
        case (mode)
            MODE_ADD: return m + p;
            MODE_SUB: return m - p;
            default:  return p;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            mode_q <= MODE_PASS;
        end else if (i_load) begin
            mode_q <= i_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            m_q <= i_m;
        end else if (i_beat) begin
            for (int i = 0; i < ROWS; i++) begin
                m_q[i] <= m_q[i] >> DATA_W;  // next M column moves into slot 0
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_beat) begin
            for (int i = 0; i < ROWS; i++) begin
                o_col.w[i] <= apply_mode(mode_q, m_q[i][0], i_drain.w[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_valid <= i_beat;
            o_done  <= i_beat && i_last;  // rides with the last column
        end
    end

endmodule

`default_nettype wire

// ==== logic/array_sequencer.sv ====
// job FSM, paces edge feeding, the clear and done strobes and the column drain of each job
`timescale 1ns/1ps
`default_nettype none

module array_sequencer
    import rsa_array_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  wire  clk,
    input  wire  i_reset,
    input  wire  i_start,
    output logic o_busy,
    output logic o_load,      // capture strobe for feeder and adder
    output logic o_feed,      // feeder steps while high
    output logic o_cal_en,    // clear into cell (0,0)
    output logic o_cal_done,  // done into cell (0,0)
    output logic o_shift,     // drain level to all cells
    output logic o_beat,      // adder takes a column
    output logic o_last
);

    seq_state_e         state_q;
    logic [CNT_W-1:0]   fcnt_q;    // feed clock, runs one ahead of the edge data
    logic [DRAIN_W-1:0] dcnt_q;    // drain beat index
    logic               tail_q;    // keeps busy up over the done cycle
    logic               accept;
    logic               drain_on;

    assign accept   = i_start && !o_busy;  // starts while busy are dropped
    assign drain_on = (state_q == SEQ_DRAIN);

    assign o_busy  = (state_q != SEQ_IDLE) || tail_q;
    assign o_load  = accept;
    assign o_feed  = (state_q == SEQ_FEED) && (fcnt_q < CNT_W'(FEED_LEN));
    assign o_shift = drain_on;
    assign o_beat  = drain_on;
    assign o_last  = drain_on && (dcnt_q == DRAIN_W'(COLS - 1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q    <= SEQ_IDLE;
            fcnt_q     <= '0;
            dcnt_q     <= '0;
            tail_q     <= 1'b0;
            o_cal_en   <= 1'b0;
            o_cal_done <= 1'b0;
        end else begin
            tail_q     <= o_last;
            // registered so they meet the registered edge data of f=0 and f=DEPTH
            o_cal_en   <= (state_q == SEQ_FEED) && (fcnt_q == '0);
            o_cal_done <= (state_q == SEQ_FEED) && (fcnt_q == CNT_W'(DEPTH));
            case (state_q)
                SEQ_IDLE: begin
                    fcnt_q <= '0;
                    dcnt_q <= '0;
                    if (accept) begin
                        state_q <= SEQ_FEED;
                    end
                end
                SEQ_FEED: begin
                    fcnt_q <= fcnt_q + 1'b1;
                    // last cell has latched, drain starts next cycle
                    if (fcnt_q == CNT_W'(LATCH_CYC)) begin
                        state_q <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    dcnt_q <= dcnt_q + 1'b1;
                    if (o_last) begin
                        state_q <= SEQ_IDLE;
                    end
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/rsa_top.sv ====
// top level of the systolic matrix engine, takes one job per start and returns C column by column
`timescale 1ns/1ps
`default_nettype none

module rsa_top
    import rsa_array_pkg::*;
    import rsa_ctrl_pkg::*;
(
    input  wire       clk,
    input  wire       i_reset,
    input  wire       i_start,
    input  wire job_t i_job,
    output logic      o_busy,
    output logic      o_valid,
    output row_vec_t  o_col,    // C[0..ROWS-1][j]
    output logic      o_done
);

    logic     load;
    logic     feed;
    logic     cal_en;
    logic     cal_done;
    logic     shift;
    logic     beat;
    logic     last;
    row_vec_t west;
    col_vec_t south;
    row_vec_t drain;

    array_sequencer u_seq (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_start    (i_start),
        .o_busy     (o_busy),
        .o_load     (load),
        .o_feed     (feed),
        .o_cal_en   (cal_en),
        .o_cal_done (cal_done),
        .o_shift    (shift),
        .o_beat     (beat),
        .o_last     (last)
    );

    operand_feeder u_feeder (
        .clk     (clk),
        .i_reset (i_reset),
        .i_load  (load),
        .i_a     (i_job.a),
        .i_b     (i_job.b),
        .i_feed  (feed),
        .o_west  (west),
        .o_south (south)
    );

    pe_array u_array (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_west     (west),
        .i_south    (south),
        .i_cal_en   (cal_en),
        .i_cal_done (cal_done),
        .i_shift    (shift),
        .o_drain    (drain)
    );

    result_adder u_adder (
        .clk     (clk),
        .i_reset (i_reset),
        .i_load  (load),
        .i_m     (i_job.m),
        .i_mode  (i_job.mode),
        .i_beat  (beat),
        .i_last  (last),
        .i_drain (drain),
        .o_valid (o_valid),
        .o_col   (o_col),
        .o_done  (o_done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_rsa_checker.sv ====
// testbench monitor, collects the output columns of each job and compares them with expected results
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_checker
    import rsa_array_pkg::*;
(
    input  wire           clk,
    input  wire           i_valid,
    input  wire row_vec_t i_col,
    input  wire           i_done,
    output int            o_data_errs,
    output int            o_beat_errs
);

    mat_t  exp_q  [$];    // expected C per job, indexed [row][col]
    string name_q [$];
    int    beat_idx = 0;  // columns already seen of the job at the head

    initial begin
        o_data_errs = 0;
        o_beat_errs = 0;
    end

    task automatic expect_job(input string name, input mat_t res);
        exp_q.push_back(res);
        name_q.push_back(name);
    endtask

    // jobs still queued at the end never delivered their columns
    task automatic flag_missing();
        while (exp_q.size() > 0) begin
            $display("missing result: job %s never delivered its columns", name_q[0]);
            o_beat_errs++;
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (i_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("extra beat: o_valid with no job outstanding");
                o_beat_errs++;
            end else begin
                for (int i = 0; i < ROWS; i++) begin
                    if (i_col.w[i] !== exp_q[0][i][beat_idx]) begin
                        $display("[FAIL] %s C[%0d][%0d]: expected %0d, actual %0d",
                                 name_q[0], i, beat_idx, exp_q[0][i][beat_idx], i_col.w[i]);
                        o_data_errs++;
                    end
                end
                if ((i_done === 1'b1) != (beat_idx == COLS - 1)) begin
                    $display("done misplaced: job %s had o_done=%b on beat %0d of %0d",
                             name_q[0], i_done, beat_idx + 1, COLS);
                    o_beat_errs++;
                end
                if (beat_idx == COLS - 1) begin
                    void'(exp_q.pop_front());
                    void'(name_q.pop_front());
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
            end
        end else begin
            if (i_done === 1'b1) begin
                $display("stray done: o_done raised without o_valid");
                o_beat_errs++;
            end
            if (beat_idx != 0) begin  // beats of one job must be back to back
                $display("missing beat: job %s stopped after %0d of %0d columns",
                         name_q[0], beat_idx, COLS);
                o_beat_errs++;
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                beat_idx = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_rsa.sv ====
// testbench top that runs random and extreme matrix jobs against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_rsa
    import rsa_array_pkg::*;
    import rsa_ctrl_pkg::*;
();

    localparam int NUM_JOBS    = 12;  // pass 3, add 2, sub 2, wrap 3, busy rule 2
    localparam int TIMEOUT_CYC = NUM_JOBS * (DEPTH + ROWS + 2 * COLS + 8) * 2;

    logic        clk = 1'b0;
    logic        i_reset;
    logic        i_start;
    job_t        i_job;
    logic        o_busy;
    logic        o_valid;
    row_vec_t    o_col;
    logic        o_done;
    int          data_errs;
    int          beat_errs;
    int          ctrl_errs = 0;  // reset and busy behavior
    int          cycles = 0;
    logic [31:0] rng_q = 32'd23;
    job_t        job;
    job_t        junk;

    rsa_top i_dut (
        .clk     (clk),
        .i_reset (i_reset),
        .i_start (i_start),
        .i_job   (i_job),
        .o_busy  (o_busy),
        .o_valid (o_valid),
        .o_col   (o_col),
        .o_done  (o_done)
    );

    tb_rsa_checker u_chk (
        .clk         (clk),
        .i_valid     (o_valid),
        .i_col       (o_col),
        .i_done      (o_done),
        .o_data_errs (data_errs),
        .o_beat_errs (beat_errs)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: no finish within %0d cycles", TIMEOUT_CYC);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // extreme words come from the corners of the signed range
    function automatic data_t next_word(input logic extreme);
        rng_q = xorshift32(rng_q);
        if (!extreme) begin
            return rng_q[15:0];
        end
        case (rng_q[1:0])
            2'd0:    return 16'h7fff;
            2'd1:    return 16'h8000;
            2'd2:    return 16'hffff;
            default: return 16'h0001;
        endcase
    endfunction

    task automatic make_job(input add_mode_e mode, input logic extreme, output job_t j);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < DEPTH; c++) begin
                j.a[r][c] = next_word(extreme);
                j.b[r][c] = next_word(extreme);
                j.m[r][c] = next_word(extreme);
            end
        end
        j.mode = mode;
    endtask

    // C = A x B kept to its low 16 bits, then combined with M as the mode says
    function automatic mat_t expected_result(input job_t j);
        mat_t res;
        int   sum;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                sum = 0;
                for (int k = 0; k < DEPTH; k++) begin
                    sum = sum + int'(j.a[r][k]) * int'(j.b[k][c]);
                end
                if (j.mode == MODE_ADD) begin
                    sum = int'(j.m[r][c]) + sum;
                end else if (j.mode == MODE_SUB) begin
                    sum = int'(j.m[r][c]) - sum;
                end
                res[r][c] = sum[DATA_W-1:0];
            end
        end
        return res;
    endfunction

    task automatic wait_idle();
        @(negedge clk);
        while (o_busy !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_busy();
        @(negedge clk);
        while (o_busy !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic run_job(input string name, input job_t j);
        wait_idle();
        @(posedge clk);
        i_start <= 1'b1;
        i_job   <= j;
        @(posedge clk);
        i_start <= 1'b0;
        u_chk.expect_job(name, expected_result(j));
        wait_busy();
    endtask

    // start is raised on the edge after o_done, so it is sampled in the first idle cycle
    task automatic run_job_back_to_back(input string name, input job_t j);
        @(negedge clk);
        while (o_done !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        i_start <= 1'b1;
        i_job   <= j;
        @(posedge clk);
        i_start <= 1'b0;
        u_chk.expect_job(name, expected_result(j));
        wait_busy();
    endtask

    // a start pulse that lands while busy, so the DUT must drop it
    task automatic ignored_start(input job_t j);
        @(negedge clk);
        if (o_busy !== 1'b1) begin
            $display("busy rule: o_busy low while a job should still be running");
            ctrl_errs++;
        end
        @(posedge clk);
        i_start <= 1'b1;
        i_job   <= j;
        @(posedge clk);
        i_start <= 1'b0;
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            if (o_busy !== 1'b0 || o_valid !== 1'b0 || o_done !== 1'b0) begin
                $display("reset: outputs active before the first start (busy=%b valid=%b done=%b)",
                         o_busy, o_valid, o_done);
                ctrl_errs++;
            end
        end
    endtask

    initial begin
        i_reset = 1'b1;
        i_start = 1'b0;
        i_job   = '0;
        repeat (2) @(posedge clk);
        i_reset <= 1'b0;
        check_quiet(6);

        for (int n = 0; n < 3; n++) begin
            make_job(MODE_PASS, 1'b0, job);
            run_job($sformatf("pass_%0d", n), job);
        end
        for (int n = 0; n < 2; n++) begin
            make_job(MODE_ADD, 1'b0, job);
            run_job($sformatf("add_%0d", n), job);
        end
        for (int n = 0; n < 2; n++) begin
            make_job(MODE_SUB, 1'b0, job);
            run_job($sformatf("sub_%0d", n), job);
        end
        make_job(MODE_PASS, 1'b1, job);
        run_job("wrap_pass", job);
        make_job(MODE_ADD, 1'b1, job);
        run_job("wrap_add", job);
        make_job(MODE_SUB, 1'b1, job);
        run_job("wrap_sub", job);

        make_job(MODE_ADD, 1'b0, job);
        run_job("busy_first", job);
        make_job(MODE_SUB, 1'b1, junk);
        repeat (3) @(posedge clk);
        ignored_start(junk);   // during the feed phase
        repeat (8) @(posedge clk);
        ignored_start(junk);   // near the drain
        make_job(MODE_SUB, 1'b0, job);
        run_job_back_to_back("busy_next", job);

        wait_idle();
        repeat (4) @(negedge clk);
        u_chk.flag_missing();
        $display("error counts: data %0d, beat %0d, control %0d",
                 data_errs, beat_errs, ctrl_errs);
        if (data_errs + beat_errs + ctrl_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/rsa_array_pkg.sv
logic/rsa_ctrl_pkg.sv
logic/pe_mac.sv
logic/pe_array.sv
logic/operand_feeder.sv
logic/result_adder.sv
logic/array_sequencer.sv
logic/rsa_top.sv
testbench/tb_rsa_checker.sv
testbench/tb_rsa.sv

// ==== Bender.yml ====
package:
  name: rsa_array

sources:
  - files:
      - logic/rsa_array_pkg.sv
      - logic/rsa_ctrl_pkg.sv
      - logic/pe_mac.sv
      - logic/pe_array.sv
      - logic/operand_feeder.sv
      - logic/result_adder.sv
      - logic/array_sequencer.sv
      - logic/rsa_top.sv
  - target: test
    files:
      - testbench/tb_rsa_checker.sv
      - testbench/tb_rsa.sv
